// ==== hw/u1e_bus_pkg.sv ====
// Bus widths, typedefs and packed request structs for Wishbone and settings bus
package u1e_bus_pkg;

   localparam int WB_AW  = 11;   // Byte address
   localparam int WB_DW  = 16;
   localparam int SET_AW = 8;
   localparam int SET_DW = 32;

   typedef logic [WB_AW-1:0]  wb_adr_t;
   typedef logic [WB_DW-1:0]  wb_dat_t;
   typedef logic [SET_AW-1:0] set_addr_t;
   typedef logic [SET_DW-1:0] set_data_t;
   typedef logic [63:0]       vita_time_t;

   // One Wishbone request as seen by a slave page
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      logic    we;
      logic    stb;
      logic    cyc;
   } wb_req_t;

   // One 32-bit settings write
   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

endpackage

// ==== hw/u1e_regmap_pkg.sv ====
// Page map, settings addresses, misc offsets, readback word indices and compat number
package u1e_regmap_pkg;

   ////////////////////
   // Wishbone pages, top 4 address bits
   localparam logic [3:0] PAGE_MISC     = 4'd0;
   localparam logic [3:0] PAGE_READBACK = 4'd7;
   localparam logic [3:0] PAGE_SETTINGS = 4'd8;   // Pages 8 to 15

   ////////////////////
   // Settings bus register numbers
   localparam logic [7:0] SR_TIME64     = 8'd42;  // 3 regs
   localparam logic [7:0] SR_REG_TEST32 = 8'd60;

   ////////////////////
   // Misc page offsets
   localparam logic [6:0] REG_CGEN_CTRL = 7'd4;
   localparam logic [6:0] REG_CGEN_ST   = 7'd6;
   localparam logic [6:0] REG_TEST      = 7'd8;

   localparam logic [15:0] MISC_DEFAULT_READ = 16'hBEEF;

   ////////////////////
   // Readback words, 32 bits each
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_PPS_HI  = 4'd2;
   localparam logic [3:0] RB_PPS_LO  = 4'd3;
   localparam logic [3:0] RB_TEST32  = 4'd4;
   localparam logic [3:0] RB_COMPAT  = 4'd5;

   // Bump when the register map changes, major in the upper half
   localparam logic [31:0] COMPAT_NUM = {16'd9, 16'd3};

endpackage

// ==== hw/wb_page_decode.sv ====
// Wishbone page decoder with strobe gating and return data and ack mux
`timescale 1ns/100ps

module wb_page_decode
   import u1e_bus_pkg::*;
   import u1e_regmap_pkg::*;
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  wb_req_t req_i,
   input  wb_dat_t misc_dat_i,
   input  logic    misc_ack_i,
   input  wb_dat_t rb_dat_i,
   input  logic    rb_ack_i,
   input  logic    set_ack_i,
   output wb_req_t misc_req_o,
   output wb_req_t rb_req_o,
   output wb_req_t set_req_o,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o
);

   logic [3:0] page;
   logic       sel_misc;
   logic       sel_rb;
   logic       sel_set;

   assign page     = req_i.adr[10:7];
   assign sel_misc = (page == PAGE_MISC);
   assign sel_rb   = (page == PAGE_READBACK);
   assign sel_set  = (page >= PAGE_SETTINGS);   // Upper half of the map

   // Same request to every page, only the selected one sees stb
   always_comb
   begin
      misc_req_o     = req_i;
      rb_req_o       = req_i;
      set_req_o      = req_i;
      misc_req_o.stb = req_i.stb & sel_misc;
      rb_req_o.stb   = req_i.stb & sel_rb;
      set_req_o.stb  = req_i.stb & sel_set;
   end

   always_comb
   begin
      if (sel_misc)
         wb_dat_o = misc_dat_i;
      else if (sel_rb)
         wb_dat_o = rb_dat_i;
      else
         wb_dat_o = '0;   // Settings page is write only
   end

   // Unmapped pages fall through with no ack
   assign wb_ack_o = (sel_misc & misc_ack_i) | (sel_rb & rb_ack_i) | (sel_set & set_ack_i);

   a_one_page: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $onehot0({misc_req_o.stb, rb_req_o.stb, set_req_o.stb}));

endmodule

// ==== hw/settings_bus_16le.sv ====
// Settings bus master building 32-bit writes from little-endian halfword writes
`timescale 1ns/100ps

module settings_bus_16le
   import u1e_bus_pkg::*;
(
   input  logic     wb_clk,
   input  logic     wb_rst,
   input  wb_req_t  req_i,
   output logic     ack_o,
   output set_bus_t set_o
);

   wb_dat_t   low_half;   // Most recent low halfword
   logic      set_stb;
   set_addr_t set_addr;
   set_data_t set_data;
   logic      wr_done;

   // Write is taken in the ack cycle, master still holds data there
   assign wr_done = req_i.stb & req_i.cyc & req_i.we & ack_o;

   ////////////////////
   // Bus acknowledge
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= req_i.stb & req_i.cyc & ~ack_o;   // Single cycle pulse
   end

   ////////////////////
   // Halfword assembly
   always_ff @(posedge wb_clk)
   begin
      if (wr_done && !req_i.adr[1])
         low_half <= req_i.dat;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wr_done && req_i.adr[1])
      begin
         set_addr <= req_i.adr[9:2];
         set_data <= {req_i.dat, low_half};
      end
   end

   // High half completes the word
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         set_stb <= 1'b0;
      else
         set_stb <= wr_done & req_i.adr[1];
   end

   assign set_o = '{stb: set_stb, addr: set_addr, data: set_data};

   a_set_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_o.stb |=> !set_o.stb);

endmodule

// ==== hw/misc_ctrl_regs.sv ====
// Misc control page with clock generator control, status and test registers
`timescale 1ns/100ps

module misc_ctrl_regs
   import u1e_bus_pkg::*;
   import u1e_regmap_pkg::*;
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  wb_req_t req_i,
   input  logic    cgen_st_status_i,
   input  logic    cgen_st_ld_i,
   input  logic    cgen_st_refmon_i,
   output wb_dat_t dat_o,
   output logic    ack_o,
   output logic    cgen_sync_b_o,
   output logic    cgen_ref_sel_o
);

   wb_dat_t    cgen_ctrl;
   wb_dat_t    test_reg;
   logic [6:0] offset;
   logic       wr_en;

   assign offset = req_i.adr[6:0];
   assign wr_en  = req_i.stb & req_i.cyc & req_i.we;

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         cgen_ctrl <= 16'd3;   // Sync released, internal ref
         test_reg  <= '0;
      end
      else if (wr_en)
      begin
         case (offset)
            REG_CGEN_CTRL: cgen_ctrl <= req_i.dat;
            REG_TEST:      test_reg  <= req_i.dat;
            default: ;
         endcase
      end
   end

   assign cgen_sync_b_o  = cgen_ctrl[1];
   assign cgen_ref_sel_o = cgen_ctrl[0];

   ////////////////////
   // Read mux
   always_comb
   begin
      case (offset)
         REG_CGEN_CTRL: dat_o = cgen_ctrl;
         REG_CGEN_ST:   dat_o = {13'd0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         REG_TEST:      dat_o = test_reg;
         default:       dat_o = MISC_DEFAULT_READ;
      endcase
   end

   assign ack_o = req_i.stb & req_i.cyc;   // Zero wait state

endmodule

// ==== hw/vita_time_64.sv ====
// 64-bit VITA time counter with immediate or PPS aligned load and PPS capture
`timescale 1ns/100ps

module vita_time_64
   import u1e_bus_pkg::*;
#(
   parameter set_addr_t BASE = 8'd0
)
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  set_bus_t   set_i,
   input  logic       pps_i,
   output vita_time_t time_o,
   output vita_time_t time_pps_o
);

   localparam set_addr_t ADDR_HI   = BASE;
   localparam set_addr_t ADDR_LO   = BASE + 8'd1;
   localparam set_addr_t ADDR_MODE = BASE + 8'd2;

   typedef enum logic [0:0] {LOAD_IDLE, LOAD_WAIT_PPS} load_state_e;

   load_state_e state;
   set_data_t   time_hi;
   set_data_t   time_lo;
   logic        pps_mode;
   logic [2:0]  pps_sync;   // Two sync flops plus edge history
   logic        pps_rise;
   logic        lo_wr;
   vita_time_t  time_next;

   assign lo_wr    = set_i.stb & (set_i.addr == ADDR_LO);
   assign pps_rise = pps_sync[1] & ~pps_sync[2];

   ////////////////////
   // Settings registers
   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == ADDR_HI)
         time_hi <= set_i.data;
      if (lo_wr)
         time_lo <= set_i.data;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         pps_mode <= 1'b0;
      else if (set_i.stb && set_i.addr == ADDR_MODE)
         pps_mode <= set_i.data[0];
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         pps_sync <= '0;
      else
         pps_sync <= {pps_sync[1:0], pps_i};
   end

   ////////////////////
   // Load FSM and counter
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         state <= LOAD_IDLE;
      else
      begin
         case (state)
            LOAD_IDLE:     if (lo_wr && pps_mode) state <= LOAD_WAIT_PPS;
            LOAD_WAIT_PPS: if (pps_rise) state <= LOAD_IDLE;
            default:       state <= LOAD_IDLE;
         endcase
      end
   end

   always_comb
   begin
      if (lo_wr && !pps_mode)
         time_next = {time_hi, set_i.data};   // Low word not yet in time_lo
      else if (state == LOAD_WAIT_PPS && pps_rise)
         time_next = {time_hi, time_lo};
      else
         time_next = time_o + 64'd1;
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         time_o     <= '0;
         time_pps_o <= '0;
      end
      else
      begin
         time_o <= time_next;
         if (pps_rise)
            time_pps_o <= time_next;   // Matches time_o right after the edge
      end
   end

endmodule

// ==== hw/readback_regs_16le.sv ====
// Readback page with persistent test32 register and 32-bit words served as halfwords
`timescale 1ns/100ps

module readback_regs_16le
   import u1e_bus_pkg::*;
   import u1e_regmap_pkg::*;
#(
   parameter set_addr_t TEST32_ADDR = 8'd0
)
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_req_t    req_i,
   input  set_bus_t   set_i,
   input  vita_time_t time_i,
   input  vita_time_t time_pps_i,
   output wb_dat_t    dat_o,
   output logic       ack_o
);

   set_data_t test32;    // Persistent scratch word
   set_data_t word;
   wb_dat_t   hi_latch;
   logic      rd_en;

   assign rd_en = req_i.stb & req_i.cyc & ~req_i.we & ~ack_o;

   always_ff @(posedge wb_clk)
   begin
      if (set_i.stb && set_i.addr == TEST32_ADDR)
         test32 <= set_i.data;
   end

   always_comb
   begin
      case (req_i.adr[5:2])
         RB_TIME_HI: word = time_i[63:32];
         RB_TIME_LO: word = time_i[31:0];
         RB_PPS_HI:  word = time_pps_i[63:32];
         RB_PPS_LO:  word = time_pps_i[31:0];
         RB_TEST32:  word = test32;
         RB_COMPAT:  word = COMPAT_NUM;
         default:    word = '0;
      endcase
   end

   // Low half read freezes the upper half for the following read
   always_ff @(posedge wb_clk)
   begin
      if (rd_en)
      begin
         if (!req_i.adr[1])
         begin
            dat_o    <= word[15:0];
            hi_latch <= word[31:16];
         end
         else
            dat_o <= hi_latch;
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
         ack_o <= 1'b0;
      else
         ack_o <= req_i.stb & req_i.cyc & ~ack_o;
   end

   a_ack_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst) ack_o |=> !ack_o);

endmodule

// ==== hw/u1e_regs_core.sv ====
// Register and timekeeping core top level with page decoder and register blocks
`timescale 1ns/100ps

module u1e_regs_core
   import u1e_bus_pkg::*;
   import u1e_regmap_pkg::*;
(
   input  logic    wb_clk,
   input  logic    wb_rst,
   input  wb_adr_t wb_adr_i,
   input  wb_dat_t wb_dat_i,
   input  logic    wb_we_i,
   input  logic    wb_stb_i,
   input  logic    wb_cyc_i,
   output wb_dat_t wb_dat_o,
   output logic    wb_ack_o,
   input  logic    pps_i,
   input  logic    cgen_st_status_i,
   input  logic    cgen_st_ld_i,
   input  logic    cgen_st_refmon_i,
   output logic    cgen_sync_b_o,
   output logic    cgen_ref_sel_o
);

   wb_req_t    bus_req;
   wb_req_t    misc_req;
   wb_req_t    rb_req;
   wb_req_t    set_req;
   wb_dat_t    misc_dat;
   wb_dat_t    rb_dat;
   logic       misc_ack;
   logic       rb_ack;
   logic       set_ack;
   set_bus_t   set_bus;
   vita_time_t vita_time;
   vita_time_t vita_time_pps;

   assign bus_req = '{adr: wb_adr_i, dat: wb_dat_i, we: wb_we_i, stb: wb_stb_i, cyc: wb_cyc_i};

   ////////////////////
   // Wishbone side
   wb_page_decode wb_page_decode_i (
      .wb_clk, .wb_rst, .req_i(bus_req),
      .misc_dat_i(misc_dat), .misc_ack_i(misc_ack),
      .rb_dat_i(rb_dat), .rb_ack_i(rb_ack), .set_ack_i(set_ack),
      .misc_req_o(misc_req), .rb_req_o(rb_req), .set_req_o(set_req),
      .wb_dat_o, .wb_ack_o);

   misc_ctrl_regs misc_ctrl_regs_i (
      .wb_clk, .wb_rst, .req_i(misc_req),
      .cgen_st_status_i, .cgen_st_ld_i, .cgen_st_refmon_i,
      .dat_o(misc_dat), .ack_o(misc_ack),
      .cgen_sync_b_o, .cgen_ref_sel_o);

   settings_bus_16le settings_bus_16le_i (
      .wb_clk, .wb_rst, .req_i(set_req), .ack_o(set_ack), .set_o(set_bus));

   ////////////////////
   // Settings bus targets
   vita_time_64 #(.BASE(SR_TIME64)) vita_time_64_i (
      .wb_clk, .wb_rst, .set_i(set_bus), .pps_i,
      .time_o(vita_time), .time_pps_o(vita_time_pps));

   readback_regs_16le #(.TEST32_ADDR(SR_REG_TEST32)) readback_regs_16le_i (
      .wb_clk, .wb_rst, .req_i(rb_req), .set_i(set_bus),
      .time_i(vita_time), .time_pps_i(vita_time_pps),
      .dat_o(rb_dat), .ack_o(rb_ack));

endmodule

// ==== test/u1e_regs_checker.sv ====
// Bus checker comparing read data, acks and clock generator pins against expected values
`timescale 1ns/100ps

module u1e_regs_checker
   import u1e_bus_pkg::*;
(
   input  logic       wb_clk,
   input  logic       wb_rst,
   input  wb_adr_t    adr_i,
   input  logic       we_i,
   input  logic       stb_i,
   input  logic       ack_i,
   input  wb_dat_t    dat_i,
   input  logic [1:0] pins_i,       // {sync_b, ref_sel}
   input  logic       exp_valid_i,  // Read in flight with a known answer
   input  wb_dat_t    exp_dat_i,
   input  logic       no_ack_i,     // Unmapped access in flight
   input  logic       pin_chk_i,
   input  logic [1:0] pin_exp_i,
   output int         mismatch_cnt_o,
   output int         bad_ack_cnt_o
);

   int mismatch_cnt = 0;
   int bad_ack_cnt  = 0;

   assign mismatch_cnt_o = mismatch_cnt;
   assign bad_ack_cnt_o  = bad_ack_cnt;

   ////////////////////
   // Sampled on the rising edge, inputs move 2 ns later
   always @(posedge wb_clk)
   begin
      if (!wb_rst)
      begin
         if (ack_i && (no_ack_i || !stb_i))
         begin
            $display("unexpected ack at %0t from address 0x%03h", $time, adr_i);
            bad_ack_cnt <= bad_ack_cnt + 1;
         end
         else if (ack_i && !we_i && exp_valid_i && dat_i !== exp_dat_i)
         begin
            $display("mismatch at %0t: read 0x%04h from address 0x%03h, expected 0x%04h",
                     $time, dat_i, adr_i, exp_dat_i);
            mismatch_cnt <= mismatch_cnt + 1;
         end
         if (pin_chk_i && pins_i !== pin_exp_i)
         begin
            $display("mismatch at %0t: cgen pins {sync_b, ref_sel} are %b, expected %b",
                     $time, pins_i, pin_exp_i);
            mismatch_cnt <= mismatch_cnt + 1;
         end
      end
   end

endmodule

// ==== test/tb_u1e_regs_core.sv ====
// Testbench top with clock, reset, golden file reader, bus driver and DUT instance
`timescale 1ns/100ps

module tb_u1e_regs_core
   import u1e_bus_pkg::*;
();

   localparam GOLDEN_FILE   = "test/u1e_regs_golden.txt";
   localparam RST_CYCLES    = 16;
   localparam ACK_TIMEOUT   = 20;
   localparam NO_ACK_CYCLES = 8;
   localparam MAX_OPS       = 1000;

   logic       wb_clk;
   logic       wb_rst;
   wb_adr_t    wb_adr;
   wb_dat_t    wb_wdat;
   wb_dat_t    wb_rdat;
   logic       wb_we;
   logic       wb_stb;
   logic       wb_cyc;
   logic       wb_ack;
   logic       pps;
   logic [2:0] cgen_st;    // {status, ld, refmon}
   logic       cgen_sync_b;
   logic       cgen_ref_sel;
   logic       exp_valid;
   wb_dat_t    exp_dat;
   logic       no_ack;
   logic       pin_chk;
   logic [1:0] pin_exp;
   int         mismatch_cnt;
   int         bad_ack_cnt;
   int         timeout_cnt;
   int         other_cnt;
   int         fd;

   always #10 wb_clk = ~wb_clk;

   u1e_regs_core u1e_regs_core_i (
      .wb_clk, .wb_rst,
      .wb_adr_i(wb_adr), .wb_dat_i(wb_wdat), .wb_we_i(wb_we),
      .wb_stb_i(wb_stb), .wb_cyc_i(wb_cyc),
      .wb_dat_o(wb_rdat), .wb_ack_o(wb_ack),
      .pps_i(pps),
      .cgen_st_status_i(cgen_st[2]), .cgen_st_ld_i(cgen_st[1]),
      .cgen_st_refmon_i(cgen_st[0]),
      .cgen_sync_b_o(cgen_sync_b), .cgen_ref_sel_o(cgen_ref_sel));

   u1e_regs_checker u1e_regs_checker_i (
      .wb_clk, .wb_rst, .adr_i(wb_adr), .we_i(wb_we), .stb_i(wb_stb),
      .ack_i(wb_ack), .dat_i(wb_rdat), .pins_i({cgen_sync_b, cgen_ref_sel}),
      .exp_valid_i(exp_valid), .exp_dat_i(exp_dat), .no_ack_i(no_ack),
      .pin_chk_i(pin_chk), .pin_exp_i(pin_exp),
      .mismatch_cnt_o(mismatch_cnt), .bad_ack_cnt_o(bad_ack_cnt));

   ////////////////////
   // Bus driver
   task automatic bus_idle();
      wb_stb    = 1'b0;
      wb_cyc    = 1'b0;
      wb_we     = 1'b0;
      exp_valid = 1'b0;
      no_ack    = 1'b0;
   endtask

   // Dat is write data, or the expected value of a read
   task automatic bus_access(input wb_adr_t adr, input wb_dat_t dat, input logic we);
      int   wait_cnt;
      logic got_ack;
      @(posedge wb_clk);
      #2;
      wb_adr    = adr;
      wb_wdat   = we ? dat : '0;
      wb_we     = we;
      wb_stb    = 1'b1;
      wb_cyc    = 1'b1;
      exp_valid = !we;
      exp_dat   = dat;
      wait_cnt  = 0;
      got_ack   = 1'b0;
      while (!got_ack && wait_cnt < ACK_TIMEOUT)
      begin
         @(posedge wb_clk);
         got_ack = wb_ack;
         wait_cnt++;
      end
      if (!got_ack)
      begin
         $display("timeout: no ack from address 0x%03h within %0d cycles", adr, ACK_TIMEOUT);
         timeout_cnt++;
      end
      #2;
      bus_idle();
   endtask

   task automatic no_ack_access(input wb_adr_t adr);
      @(posedge wb_clk);
      #2;
      wb_adr = adr;
      wb_stb = 1'b1;
      wb_cyc = 1'b1;
      no_ack = 1'b1;   // Checker flags any ack here
      for (int i = 0; i < NO_ACK_CYCLES; i++)
         @(posedge wb_clk);
      #2;
      bus_idle();
   endtask

   task automatic hold_reset();
      wb_rst = 1'b1;
      repeat (RST_CYCLES) @(posedge wb_clk);
      #2;
      wb_rst = 1'b0;
   endtask

   // Long enough for the synchronizer and the load behind it
   task automatic pps_pulse();
      @(posedge wb_clk);
      #2;
      pps = 1'b1;
      repeat (4) @(posedge wb_clk);
      #2;
      pps = 1'b0;
      repeat (4) @(posedge wb_clk);
      #2;
   endtask

   task automatic check_pins(input logic [1:0] val);
      @(posedge wb_clk);
      #2;
      pin_exp = val;
      pin_chk = 1'b1;
      @(posedge wb_clk);
      #2;
      pin_chk = 1'b0;
   endtask

   ////////////////////
   // Golden file reader
   task automatic skip_line();
      int c;
      int n;
      c = 0;
      n = 0;
      while (c != "\n" && c != -1 && n < 256)
      begin
         c = $fgetc(fd);
         n++;
      end
   endtask

   task automatic bad_line(input logic [7:0] op);
      $display("bad line in golden file at operation '%c'", op);
      other_cnt++;
      skip_line();
   endtask

   task automatic run_op(input logic [7:0] op);
      logic [31:0] arg0;
      logic [31:0] arg1;
      int          code;
      case (op)
         "W", "R":
         begin
            code = $fscanf(fd, "%h %h", arg0, arg1);
            if (code != 2)
               bad_line(op);
            else
               bus_access(arg0[10:0], arg1[15:0], op == "W");
         end
         "X", "T", "C":
         begin
            code = $fscanf(fd, "%h", arg0);
            if (code != 1)
               bad_line(op);
            else if (op == "X")
               no_ack_access(arg0[10:0]);
            else if (op == "T")
            begin
               @(posedge wb_clk);
               #2;
               cgen_st = arg0[2:0];
            end
            else
               check_pins(arg0[1:0]);
         end
         "P": pps_pulse();
         "S":
         begin
            @(posedge wb_clk);
            #2;
            hold_reset();
         end
         "#": skip_line();   // Comment line
         default: bad_line(op);
      endcase
   endtask

   initial
   begin
      int         code;
      int         n_ops;
      logic       done;
      logic [7:0] op;
      wb_clk      = 1'b0;
      wb_rst      = 1'b1;
      wb_adr      = '0;
      wb_wdat     = '0;
      exp_dat     = '0;
      pps         = 1'b0;
      cgen_st     = 3'b000;
      pin_chk     = 1'b0;
      pin_exp     = 2'b00;
      timeout_cnt = 0;
      other_cnt   = 0;
      bus_idle();
      hold_reset();
      fd = $fopen(GOLDEN_FILE, "r");
      if (fd == 0)
      begin
         $display("cannot open golden file %s", GOLDEN_FILE);
         other_cnt++;
      end
      else
      begin
         n_ops = 0;
         done  = 1'b0;
         while (!done && n_ops < MAX_OPS)
         begin
            code = $fscanf(fd, " %c", op);
            if (code != 1)
               done = 1'b1;
            else
               run_op(op);
            n_ops++;
         end
         if (!done)
         begin
            $display("golden file has more than %0d operations", MAX_OPS);
            other_cnt++;
         end
         $fclose(fd);
      end
      @(posedge wb_clk);
      #2;
      $display("error counts: mismatch %0d, unexpected ack %0d, timeout %0d, other %0d",
               mismatch_cnt, bad_ack_cnt, timeout_cnt, other_cnt);
      if (mismatch_cnt + bad_ack_cnt + timeout_cnt + other_cnt == 0)
         $display("TEST PASS");
      else
         $display("TEST FAIL");
      $finish;
   end

endmodule

// ==== test/u1e_regs_golden.txt ====
# Op Addr Data: W writes data, R reads and expects data, X expects no ack
# P pulses pps, S pulses reset, T drives cgen status bits, C expects {sync_b, ref_sel}
C 3
R 004 0003
W 004 0000
C 0
R 004 0000
W 008 a5c3
R 008 a5c3
R 00a beef
T 5
R 006 0005
T 2
R 006 0002
W 4f0 cafe
W 4f2 dead
R 390 cafe
R 392 dead
S
C 3
R 008 0000
R 390 cafe
R 392 dead
R 394 0003
R 396 0009
W 4b0 0000
W 4b2 0000
W 4a8 5678
W 4aa 1234
W 4ac 0000
W 4ae 0000
R 380 5678
R 382 1234
W 4b0 0001
W 4b2 0000
W 4a8 abcd
W 4aa 0000
W 4ac 0000
W 4ae 0000
R 380 5678
R 382 1234
P
R 380 abcd
R 382 0000
R 388 abcd
R 38a 0000
X 080
R 00a beef

// ==== files.f ====
hw/u1e_bus_pkg.sv
hw/u1e_regmap_pkg.sv
hw/wb_page_decode.sv
hw/settings_bus_16le.sv
hw/misc_ctrl_regs.sv
hw/vita_time_64.sv
hw/readback_regs_16le.sv
hw/u1e_regs_core.sv
test/u1e_regs_checker.sv
test/tb_u1e_regs_core.sv

// ==== Bender.yml ====
package:
  name: u1e_regs_core

sources:
  - files:
      - hw/u1e_bus_pkg.sv
      - hw/u1e_regmap_pkg.sv
      - hw/wb_page_decode.sv
      - hw/settings_bus_16le.sv
      - hw/misc_ctrl_regs.sv
      - hw/vita_time_64.sv
      - hw/readback_regs_16le.sv
      - hw/u1e_regs_core.sv
  - target: test
    files:
      - test/u1e_regs_checker.sv
      - test/tb_u1e_regs_core.sv
